/* source/mmuPkg.sv */
package mmuPkg;

  // Address sizing
  localparam int vaWidth = 32;
  localparam int paWidth = 32;
  localparam int descWidth = 32;
  localparam int pageOffsetWidth = 12;
  localparam int sectionOffsetWidth = 20;
  localparam int tagWidth = vaWidth - pageOffsetWidth;
  localparam int frameWidth = paWidth - pageOffsetWidth;
  localparam int sectionTagWidth = vaWidth - sectionOffsetWidth;
  localparam int tableBaseWidth = 18;
  localparam int coarseBaseWidth = 22;

  // TLB sizing
  localparam int tlbEntries = 8;
  localparam int tlbIndexWidth = $clog2(tlbEntries);

  // Access permission, bit 1 user allowed, bit 0 write allowed
  localparam int apWidth = 2;
  // Small page AP0 field in the level-two word
  localparam int l2ApLsb = 4;

  // Descriptor type field, same place at both levels
  localparam logic [1:0] descFault = 2'd0;
  localparam logic [1:0] descCoarse = 2'd1;
  localparam logic [1:0] descSection = 2'd2;

  // Walker states
  localparam int walkStateWidth = 2;
  localparam logic [walkStateWidth-1:0] walkIdle = 2'd0;
  localparam logic [walkStateWidth-1:0] walkL1 = 2'd1;
  localparam logic [walkStateWidth-1:0] walkL2Req = 2'd2;
  localparam logic [walkStateWidth-1:0] walkL2 = 2'd3;

  localparam int faultCodeWidth = 4;

  typedef enum logic [faultCodeWidth-1:0] {
    sectionTranslation = 4'b0101,
    pageTranslation = 4'b0111,
    sectionPermission = 4'b1101,
    pagePermission = 4'b1111
  } faultCodeT;

  // Level-one descriptor word, read as section or coarse pointer
  typedef union packed {
    struct packed {
      logic [sectionTagWidth-1:0] base;
      logic [7:0] sbz;
      logic [apWidth-1:0] ap;
      logic [7:0] ignored;
      logic [1:0] kind;
    } section;
    struct packed {
      logic [coarseBaseWidth-1:0] base;
      logic [7:0] ignored;
      logic [1:0] kind;
    } coarse;
  } descriptorT;

endpackage

/* source/tlb.sv */
`timescale 1ns/1ps

module tlb
  import mmuPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  lookup,
  input  logic [vaWidth-1:0]    virtAddr,
  input  logic                  flush,
  input  logic                  fillValid,
  input  logic [tagWidth-1:0]   fillTag,
  input  logic                  fillSection,
  input  logic [frameWidth-1:0] fillPhysBase,
  input  logic [apWidth-1:0]    fillAp,
  output logic                  hit,
  output logic                  miss,
  output logic [frameWidth-1:0] hitPhysBase,
  output logic                  hitSection,
  output logic [apWidth-1:0]    hitAp
);

  // Entry storage
  logic [tlbEntries-1:0] entryValid;
  logic [tlbEntries-1:0] entrySection;
  logic [tagWidth-1:0] entryTag [tlbEntries];
  logic [frameWidth-1:0] entryPhysBase [tlbEntries];
  logic [apWidth-1:0] entryAp [tlbEntries];

  // Next slot to replace
  logic [tlbIndexWidth-1:0] fillPtr;

  logic [tlbEntries-1:0] match;
  logic [tlbIndexWidth-1:0] matchIdx;

  // Sections only compare the top 12 bits of the tag
  always_comb begin
    for (int i = 0; i < tlbEntries; i++) begin
      if (entrySection[i]) begin
        match[i] = entryValid[i] &&
          (entryTag[i][tagWidth-1 -: sectionTagWidth] == virtAddr[vaWidth-1 -: sectionTagWidth]);
      end else begin
        match[i] = entryValid[i] && (entryTag[i] == virtAddr[vaWidth-1 -: tagWidth]);
      end
    end
  end

  // Lowest matching slot wins
  always_comb begin
    matchIdx = '0;
    for (int i = tlbEntries - 1; i >= 0; i--) begin
      if (match[i]) begin
        matchIdx = tlbIndexWidth'(i);
      end
    end
  end

  // Lookup result is one cycle behind the request
  always_ff @(posedge clk) begin
    if (rst) begin
      hit <= 1'b0;
      miss <= 1'b0;
    end else begin
      hit <= lookup && (|match);
      miss <= lookup && !(|match);
    end
  end

  always_ff @(posedge clk) begin
    hitPhysBase <= entryPhysBase[matchIdx];
    hitSection <= entrySection[matchIdx];
    hitAp <= entryAp[matchIdx];
  end

  // Valid bits and round-robin pointer
  always_ff @(posedge clk) begin
    if (rst) begin
      entryValid <= '0;
      fillPtr <= '0;
    end else if (flush) begin
      entryValid <= '0;
    end else if (fillValid) begin
      entryValid[fillPtr] <= 1'b1;
      // Wraps after the last slot
      fillPtr <= fillPtr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fillValid) begin
      entryTag[fillPtr] <= fillTag;
      entrySection[fillPtr] <= fillSection;
      entryPhysBase[fillPtr] <= fillPhysBase;
      entryAp[fillPtr] <= fillAp;
    end
  end

endmodule

/* source/tableWalker.sv */
`timescale 1ns/1ps

module tableWalker
  import mmuPkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  input  logic [vaWidth-1:0]        virtAddr,
  input  logic [tableBaseWidth-1:0] tableBase,
  input  logic                      memRsp,
  input  logic [descWidth-1:0]      memData,
  output logic                      memReq,
  output logic [paWidth-1:0]        memAddr,
  output logic                      fillValid,
  output logic [tagWidth-1:0]       fillTag,
  output logic                      fillSection,
  output logic [frameWidth-1:0]     fillPhysBase,
  output logic [apWidth-1:0]        fillAp,
  output logic                      walkDone,
  output logic                      walkFault,
  output faultCodeT                 walkFaultCode
);

  logic [walkStateWidth-1:0] state;
  logic [vaWidth-1:0] vaQ;
  logic [coarseBaseWidth-1:0] l2Base;
  descriptorT l1Desc;
  logic [1:0] l2Kind;

  // Same response word, read per level
  assign l1Desc = descriptorT'(memData);
  assign l2Kind = memData[1:0];

  // First read goes out in the miss cycle, second from its own state
  assign memReq = (state == walkIdle && start) || (state == walkL2Req);

  always_comb begin
    if (state == walkL2Req) begin
      // Coarse table base, index from bits 19:12
      memAddr = {l2Base, vaQ[sectionOffsetWidth-1:pageOffsetWidth], 2'b00};
    end else begin
      // Level-one table, index from bits 31:20
      memAddr = {tableBase, vaQ[vaWidth-1 -: sectionTagWidth], 2'b00};
    end
  end

  // TLB refill coincides with walkDone
  assign fillValid = walkDone;
  assign fillTag = vaQ[vaWidth-1 -: tagWidth];

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= walkIdle;
      walkDone <= 1'b0;
      walkFault <= 1'b0;
    end else begin
      // Single-cycle strobes
      walkDone <= 1'b0;
      walkFault <= 1'b0;
      case (state)
        walkIdle: begin
          if (start) begin
            state <= walkL1;
          end
        end
        walkL1: begin
          if (memRsp) begin
            if (l1Desc.section.kind == descSection) begin
              walkDone <= 1'b1;
              state <= walkIdle;
            end else if (l1Desc.coarse.kind == descCoarse) begin
              state <= walkL2Req;
            end else begin
              // Fault type, fine tables are also treated as faults
              walkFault <= 1'b1;
              state <= walkIdle;
            end
          end
        end
        walkL2Req: begin
          state <= walkL2;
        end
        walkL2: begin
          if (memRsp) begin
            if (l2Kind == descFault) begin
              walkFault <= 1'b1;
            end else begin
              walkDone <= 1'b1;
            end
            state <= walkIdle;
          end
        end
        default: begin
          state <= walkIdle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    // Miss strobe lags the request by a cycle, so keep the idle-time address
    if (state == walkIdle && !start) begin
      vaQ <= virtAddr;
    end
    if (state == walkL1 && memRsp) begin
      l2Base <= l1Desc.coarse.base;
      fillSection <= 1'b1;
      fillPhysBase <= {l1Desc.section.base, {(sectionOffsetWidth - pageOffsetWidth){1'b0}}};
      fillAp <= l1Desc.section.ap;
      walkFaultCode <= sectionTranslation;
    end
    if (state == walkL2 && memRsp) begin
      // Small page, AP0 applies to the whole page
      fillSection <= 1'b0;
      fillPhysBase <= memData[descWidth-1 -: frameWidth];
      fillAp <= memData[l2ApLsb +: apWidth];
      walkFaultCode <= pageTranslation;
    end
  end

endmodule

/* source/faultUnit.sv */
`timescale 1ns/1ps

module faultUnit
  import mmuPkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      reqValid,
  input  logic                      enable,
  input  logic [vaWidth-1:0]        virtAddr,
  input  logic                      write,
  input  logic                      user,
  input  logic                      tlbHit,
  input  logic [frameWidth-1:0]     hitPhysBase,
  input  logic                      hitSection,
  input  logic [apWidth-1:0]        hitAp,
  input  logic                      walkDone,
  input  logic                      walkFault,
  input  faultCodeT                 walkFaultCode,
  input  logic                      walkSection,
  input  logic [frameWidth-1:0]     walkPhysBase,
  input  logic [apWidth-1:0]        walkAp,
  output logic                      done,
  output logic [paWidth-1:0]        physAddr,
  output logic                      faultValid,
  output logic [faultCodeWidth-1:0] faultCode,
  output logic [vaWidth-1:0]        faultAddr,
  output logic                      busy
);

  logic [vaWidth-1:0] vaQ;
  logic writeQ;
  logic userQ;
  logic enableQ;
  logic entryReady;
  logic entrySection;
  logic permOk;
  logic [frameWidth-1:0] entryPhysBase;
  logic [apWidth-1:0] entryAp;
  faultCodeT codeNow;
  logic [faultCodeWidth-1:0] faultCodeQ;
  logic [vaWidth-1:0] faultAddrQ;

  // Entry comes from the TLB or the finished walk
  assign entryReady = tlbHit || walkDone;
  assign entrySection = tlbHit ? hitSection : walkSection;
  assign entryPhysBase = tlbHit ? hitPhysBase : walkPhysBase;
  assign entryAp = tlbHit ? hitAp : walkAp;

  // User needs bit 1, write needs bit 0
  assign permOk = (!userQ || entryAp[1]) && (!writeQ || entryAp[0]);

  // Walker translation faults come first
  assign codeNow = walkFault ? walkFaultCode :
                   (entrySection ? sectionPermission : pagePermission);

  // MMU off bypasses translation and checks
  assign done = busy && (!enableQ || (entryReady && permOk));
  assign faultValid = busy && enableQ && (walkFault || (entryReady && !permOk));

  always_comb begin
    if (!enableQ) begin
      physAddr = vaQ;
    end else if (entrySection) begin
      physAddr = {entryPhysBase[frameWidth-1 -: sectionTagWidth], vaQ[sectionOffsetWidth-1:0]};
    end else begin
      physAddr = {entryPhysBase, vaQ[pageOffsetWidth-1:0]};
    end
  end

  // Status visible during the strobe, then held
  assign faultCode = faultValid ? codeNow : faultCodeQ;
  assign faultAddr = faultValid ? vaQ : faultAddrQ;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
    end else if (reqValid && !busy) begin
      busy <= 1'b1;
    end else if (done || faultValid) begin
      busy <= 1'b0;
    end
  end

  // Request attributes
  always_ff @(posedge clk) begin
    if (reqValid && !busy) begin
      vaQ <= virtAddr;
      writeQ <= write;
      userQ <= user;
      enableQ <= enable;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      faultCodeQ <= '0;
      faultAddrQ <= '0;
    end else if (faultValid) begin
      faultCodeQ <= codeNow;
      faultAddrQ <= vaQ;
    end
  end

endmodule

/* source/mmu.sv */
`timescale 1ns/1ps

module mmu
  import mmuPkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      reqValid,
  input  logic [vaWidth-1:0]        virtAddr,
  input  logic                      write,
  input  logic                      user,
  input  logic                      enable,
  input  logic [tableBaseWidth-1:0] tableBase,
  input  logic                      flush,
  output logic                      done,
  output logic [paWidth-1:0]        physAddr,
  output logic                      faultValid,
  output logic [faultCodeWidth-1:0] faultCode,
  output logic [vaWidth-1:0]        faultAddr,
  output logic                      busy,
  output logic                      memReq,
  output logic [paWidth-1:0]        memAddr,
  input  logic                      memRsp,
  input  logic [descWidth-1:0]      memData
);

  logic tlbHit;
  logic tlbMiss;
  logic [frameWidth-1:0] hitPhysBase;
  logic hitSection;
  logic [apWidth-1:0] hitAp;
  logic fillValid;
  logic [tagWidth-1:0] fillTag;
  logic fillSection;
  logic [frameWidth-1:0] fillPhysBase;
  logic [apWidth-1:0] fillAp;
  logic walkDone;
  logic walkFault;
  faultCodeT walkFaultCode;

  // Only accepted, translated requests look up the TLB
  wire lookup = reqValid && enable && !busy;
  // Flush waits for an idle MMU
  wire tlbFlush = flush && !busy;

  tlb tlb0 (
    .clk(clk), .rst(rst), .lookup(lookup), .virtAddr(virtAddr), .flush(tlbFlush),
    .fillValid(fillValid), .fillTag(fillTag), .fillSection(fillSection),
    .fillPhysBase(fillPhysBase), .fillAp(fillAp),
    .hit(tlbHit), .miss(tlbMiss), .hitPhysBase(hitPhysBase), .hitSection(hitSection),
    .hitAp(hitAp)
  );

  tableWalker walker0 (
    .clk(clk), .rst(rst), .start(tlbMiss), .virtAddr(virtAddr), .tableBase(tableBase),
    .memRsp(memRsp), .memData(memData), .memReq(memReq), .memAddr(memAddr),
    .fillValid(fillValid), .fillTag(fillTag), .fillSection(fillSection),
    .fillPhysBase(fillPhysBase), .fillAp(fillAp),
    .walkDone(walkDone), .walkFault(walkFault), .walkFaultCode(walkFaultCode)
  );

  faultUnit fault0 (
    .clk(clk), .rst(rst), .reqValid(reqValid), .enable(enable), .virtAddr(virtAddr),
    .write(write), .user(user), .tlbHit(tlbHit), .hitPhysBase(hitPhysBase),
    .hitSection(hitSection), .hitAp(hitAp), .walkDone(walkDone), .walkFault(walkFault),
    .walkFaultCode(walkFaultCode), .walkSection(fillSection), .walkPhysBase(fillPhysBase),
    .walkAp(fillAp), .done(done), .physAddr(physAddr), .faultValid(faultValid),
    .faultCode(faultCode), .faultAddr(faultAddr), .busy(busy)
  );

endmodule

/* testbench/mmu_checker.sv */
`timescale 1ns/1ps

module mmuChecker (
  input logic clk,
  input logic rst,
  input logic accepted,
  input logic done,
  input logic faultValid,
  input logic activity
);

  localparam int maxWait = 24;

  logic pending;
  logic [7:0] waitCycles;

  // Cycles since the request was accepted
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
      waitCycles <= '0;
    end else if (done || faultValid) begin
      pending <= 1'b0;
      waitCycles <= '0;
    end else if (accepted) begin
      pending <= 1'b1;
      waitCycles <= '0;
    end else if (pending) begin
      waitCycles <= waitCycles + 8'd1;
    end
  end

  // One result strobe per request
  strobesExclusive: assert property (@(posedge clk) disable iff (rst) !(done && faultValid))
    else $error("done and fault strobes high in the same cycle");

  // Inner strobes only between accept and result
  activityInRequest: assert property (@(posedge clk) disable iff (rst)
    !activity || accepted || pending)
    else $error("strobe seen with no request open");

  requestEnds: assert property (@(posedge clk) disable iff (rst)
    !pending || (waitCycles < 8'(maxWait)))
    else $error("accepted request did not complete in time");

endmodule

bind faultUnit mmuChecker faultCheck0 (
  .clk(clk), .rst(rst), .accepted(reqValid && !busy), .done(done),
  .faultValid(faultValid), .activity(tlbHit || walkDone || walkFault)
);

bind tableWalker mmuChecker walkCheck0 (
  .clk(clk), .rst(rst), .accepted(start), .done(walkDone),
  .faultValid(walkFault), .activity(memReq)
);

/* testbench/mmuTb.sv */
`timescale 1ns/1ps

module mmuTb
  import mmuPkg::*;
;

  localparam logic [17:0] tableBaseVal = 18'h00400;
  localparam int waitLimit = 40;

  logic clk;
  logic rst;
  logic reqValid;
  logic [31:0] virtAddr;
  logic write;
  logic user;
  logic enable;
  logic [17:0] tableBase;
  logic flush;
  logic memRsp;
  logic [31:0] memData;
  logic done;
  logic [31:0] physAddr;
  logic faultValid;
  logic [3:0] faultCode;
  logic [31:0] faultAddr;
  logic busy;
  logic memReq;
  logic [31:0] memAddr;

  // Sparse page-table memory and a log of walker reads
  logic [31:0] pageMem [logic [31:0]];
  logic [31:0] reqLog [$];
  integer seed = 32'h5ef7_0415;

  int errorCount = 0;
  int checkCount = 0;
  int testCount = 0;
  int testStart;
  logic gotDone;
  logic gotFault;
  int latency;
  logic [31:0] resultPa;
  logic [3:0] resultCode;
  logic [31:0] resultAddr;

  mmu dut0 (
    .clk(clk), .rst(rst), .reqValid(reqValid), .virtAddr(virtAddr), .write(write),
    .user(user), .enable(enable), .tableBase(tableBase), .flush(flush), .done(done),
    .physAddr(physAddr), .faultValid(faultValid), .faultCode(faultCode),
    .faultAddr(faultAddr), .busy(busy), .memReq(memReq), .memAddr(memAddr),
    .memRsp(memRsp), .memData(memData)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Memory answers each read 1 to 4 cycles later, a single-cycle strobe
  initial begin
    int delay;
    logic [31:0] addr;
    memRsp = 1'b0;
    memData = '0;
    forever begin
      @(negedge clk);
      if (memReq) begin
        addr = memAddr;
        reqLog.push_back(addr);
        delay = 1 + ($unsigned($random(seed)) % 4);
        repeat (delay) @(posedge clk);
        #1;
        memRsp = 1'b1;
        // Missing entries read as a fault descriptor
        memData = pageMem.exists(addr) ? pageMem[addr] : 32'h0;
        @(posedge clk);
        #1;
        memRsp = 1'b0;
      end
    end
  end

  // Level-one address from the table base and VA bits 31:20
  function automatic logic [31:0] l1Addr(input logic [31:0] va);
    return {tableBaseVal, va[31:20], 2'b00};
  endfunction

  function automatic logic [31:0] l2Addr(input logic [21:0] coarseBase, input logic [31:0] va);
    return {coarseBase, va[19:12], 2'b00};
  endfunction

  task automatic mapSection(input logic [31:0] va, input logic [11:0] base, input logic [1:0] ap);
    pageMem[l1Addr(va)] = {base, 8'h00, ap, 8'h00, 2'b10};
  endtask

  task automatic mapCoarse(input logic [31:0] va, input logic [21:0] coarseBase);
    pageMem[l1Addr(va)] = {coarseBase, 8'h00, 2'b01};
  endtask

  // Small page, frame in bits 31:12 and AP in bits 5:4
  task automatic mapPage(input logic [31:0] va, input logic [21:0] coarseBase,
                         input logic [19:0] frame, input logic [1:0] ap);
    pageMem[l2Addr(coarseBase, va)] = {frame, 6'h00, ap, 2'b00, 2'b10};
  endtask

  task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    checkCount++;
    assert (actual === expected) else begin
      $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      errorCount++;
    end
  endtask

  task automatic awaitResult();
    int cycles;
    cycles = 0;
    gotDone = 1'b0;
    gotFault = 1'b0;
    while (!gotDone && !gotFault && cycles < waitLimit) begin
      @(negedge clk);
      cycles++;
      gotDone = done;
      gotFault = faultValid;
      resultPa = physAddr;
      resultCode = faultCode;
      resultAddr = faultAddr;
      // Busy covers the whole request, result cycle included
      checkEqual(busy, 1'b1, "busy");
    end
    latency = cycles;
    if (!gotDone && !gotFault) begin
      $display("timeout: request to %h ended with neither done nor a fault", virtAddr);
      errorCount++;
    end else begin
      // Busy drops right after the result strobe
      @(negedge clk);
      checkEqual(busy, 1'b0, "busy after result");
    end
  endtask

  task automatic translate(input logic [31:0] va, input logic wr, input logic usr,
                           input logic en);
    reqLog.delete();
    @(posedge clk);
    #1;
    reqValid = 1'b1;
    virtAddr = va;
    write = wr;
    user = usr;
    enable = en;
    @(posedge clk);
    #1;
    reqValid = 1'b0;
    awaitResult();
  endtask

  task automatic expectDone(input logic [31:0] pa);
    checkEqual(gotDone, 1'b1, "done");
    checkEqual(resultPa, pa, "physAddr");
  endtask

  task automatic expectFault(input faultCodeT code, input logic [31:0] va);
    checkEqual(gotFault, 1'b1, "faultValid");
    checkEqual(resultCode, code, "faultCode");
    checkEqual(resultAddr, va, "faultAddr");
  endtask

  task automatic flushTlb();
    @(posedge clk);
    #1;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
  endtask

  task automatic finishTest(input string name);
    testCount++;
    $display("%-18s %s", name, (errorCount == testStart) ? "passed" : "FAILED");
  endtask

  task automatic testBypass();
    testStart = errorCount;
    translate(32'h1234_5678, 1'b1, 1'b1, 1'b0);
    expectDone(32'h1234_5678);
    checkEqual(latency, 1, "bypass latency");
    checkEqual(reqLog.size(), 0, "bypass memReq count");
    finishTest("bypass");
  endtask

  task automatic testSection();
    testStart = errorCount;
    mapSection(32'h3000_0000, 12'h8A5, 2'b11);
    translate(32'h3001_2345, 1'b0, 1'b0, 1'b1);
    expectDone({12'h8A5, 20'h12345});
    checkEqual(reqLog.size(), 1, "section memReq count");
    checkEqual(reqLog[0], {tableBaseVal, 12'h300, 2'b00}, "section L1 address");
    // Same section again, TLB hit
    translate(32'h300A_BCDE, 1'b1, 1'b1, 1'b1);
    expectDone({12'h8A5, 20'hABCDE});
    checkEqual(latency, 1, "section hit latency");
    checkEqual(reqLog.size(), 0, "section hit memReq count");
    finishTest("section");
  endtask

  task automatic testCoarse();
    testStart = errorCount;
    mapCoarse(32'h4000_0000, 22'h00_0A5C);
    mapPage(32'h4005_6000, 22'h00_0A5C, 20'hABCDE, 2'b11);
    translate(32'h4005_6789, 1'b0, 1'b0, 1'b1);
    expectDone({20'hABCDE, 12'h789});
    checkEqual(reqLog.size(), 2, "coarse memReq count");
    checkEqual(reqLog[0], {tableBaseVal, 12'h400, 2'b00}, "coarse L1 address");
    checkEqual(reqLog[1], {22'h00_0A5C, 8'h56, 2'b00}, "coarse L2 address");
    translate(32'h4005_6004, 1'b0, 1'b0, 1'b1);
    expectDone({20'hABCDE, 12'h004});
    checkEqual(latency, 1, "page hit latency");
    finishTest("coarse");
  endtask

  task automatic testTranslationFault();
    testStart = errorCount;
    // No level-one entry at 0x500
    translate(32'h5000_1000, 1'b0, 1'b0, 1'b1);
    expectFault(sectionTranslation, 32'h5000_1000);
    mapCoarse(32'h6000_0000, 22'h00_1F00);
    translate(32'h6003_4ABC, 1'b0, 1'b0, 1'b1);
    expectFault(pageTranslation, 32'h6003_4ABC);
    checkEqual(reqLog.size(), 2, "page fault memReq count");
    // Status registers hold after the strobe
    @(negedge clk);
    checkEqual(faultCode, pageTranslation, "held faultCode");
    checkEqual(faultAddr, 32'h6003_4ABC, "held faultAddr");
    finishTest("translation fault");
  endtask

  task automatic testPermission();
    testStart = errorCount;
    mapSection(32'h7000_0000, 12'h3C1, 2'b00);
    translate(32'h7000_0010, 1'b0, 1'b1, 1'b1);
    expectFault(sectionPermission, 32'h7000_0010);
    translate(32'h7000_0010, 1'b1, 1'b0, 1'b1);
    expectFault(sectionPermission, 32'h7000_0010);
    translate(32'h7000_0010, 1'b0, 1'b0, 1'b1);
    expectDone({12'h3C1, 20'h00010});
    // User allowed, writes not allowed
    mapCoarse(32'h7100_0000, 22'h00_1B2C);
    mapPage(32'h7102_3000, 22'h00_1B2C, 20'h55AA0, 2'b10);
    translate(32'h7102_3456, 1'b1, 1'b1, 1'b1);
    expectFault(pagePermission, 32'h7102_3456);
    translate(32'h7102_3456, 1'b0, 1'b1, 1'b1);
    expectDone({20'h55AA0, 12'h456});
    translate(32'h7102_3456, 1'b1, 1'b0, 1'b1);
    expectFault(pagePermission, 32'h7102_3456);
    translate(32'h7102_3456, 1'b0, 1'b0, 1'b1);
    expectDone({20'h55AA0, 12'h456});
    finishTest("permission");
  endtask

  task automatic testFlushReplace();
    testStart = errorCount;
    flushTlb();
    translate(32'h3001_2345, 1'b0, 1'b0, 1'b1);
    expectDone({12'h8A5, 20'h12345});
    checkEqual(reqLog.size(), 1, "walk after flush");
    // Eight new sections wrap the round-robin pointer onto the first entry
    for (int i = 0; i < 8; i++) begin
      mapSection({12'h900 + 12'(i), 20'h0}, 12'hC00 + 12'(i), 2'b11);
      translate({12'h900 + 12'(i), 20'h00ABC}, 1'b0, 1'b0, 1'b1);
      expectDone({12'hC00 + 12'(i), 20'h00ABC});
      checkEqual(reqLog.size(), 1, "fill walk");
    end
    translate(32'h3001_2345, 1'b0, 1'b0, 1'b1);
    expectDone({12'h8A5, 20'h12345});
    checkEqual(reqLog.size(), 1, "walk after replacement");
    translate(32'h9070_0000, 1'b0, 1'b0, 1'b1);
    expectDone({12'hC07, 20'h00000});
    checkEqual(latency, 1, "newest entry hit latency");
    checkEqual(reqLog.size(), 0, "newest entry still hits");
    finishTest("flush and replace");
  endtask

  initial begin
    rst = 1'b1;
    reqValid = 1'b0;
    virtAddr = '0;
    write = 1'b0;
    user = 1'b0;
    enable = 1'b0;
    tableBase = tableBaseVal;
    flush = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    testBypass();
    testSection();
    testCoarse();
    testTranslationFault();
    testPermission();
    testFlushReplace();
    $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* sources.f */
source/mmuPkg.sv
source/tlb.sv
source/tableWalker.sv
source/faultUnit.sv
source/mmu.sv
testbench/mmu_checker.sv
testbench/mmuTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and judge the log

cd "$(dirname "$0")" || exit 1
logFile=sim.log
rm -f "$logFile"

verilator --binary --timing --assert -Wno-fatal --top-module mmuTb -f sources.f -o mmuSim \
  && ./obj_dir/mmuSim > "$logFile" 2>&1 \
  || echo "Simulation failed" >> "$logFile"

cat "$logFile"
! grep -q "Simulation failed" "$logFile"
